// File: all.f
clock_pkg.sv
tick_gen.sv
button_ctrl.sv
time_keeper.sv
field_encoder.sv
display_scan.sv
clock_top.sv
tb_clock_top.sv

// File: Makefile
TOP = tb_clock_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_clock_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_top;

	localparam int SEC_DIV      = 40;
	localparam int SCAN_DIV     = 2;
	localparam int BLINK_DIV    = 400;
	localparam int SAMPLE_DIV   = 4;
	localparam int DAY          = 86400;		// seconds per day
	localparam int PRESS_CYC    = 8 * SAMPLE_DIV;	// 4 samples high, 4 low
	localparam int READ_MAX     = 1000;
	localparam int WATCHDOG_CYC = 400 * PRESS_CYC + 200 * SEC_DIV + 8 * READ_MAX;
	localparam int BTN_MODE     = 0;
	localparam int BTN_POS      = 1;
	localparam int BTN_INC      = 2;
	localparam int BTN_ALARM    = 3;

	// own decimal table, a is the msb
	localparam clock_pkg::seg_t SEG_TAB [10] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33,
						     7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h73};

	logic            clk;
	logic            rst_n;
	logic [3:0]      btns;	// {alarm, inc, pos, mode}
	logic [5:0]      seg_enb;
	clock_pkg::seg_t seg;
	logic            seg_dp;
	logic            alarm;

	// reference model state
	int          m_cyc;	// edges since reset release
	logic [3:0]  m_s0;
	logic [3:0]  m_s1;
	logic [3:0]  m_s2;
	logic        m_inc;
	int          m_mode;	// 0 clock, 1 setup, 2 alarm
	int          m_pos;	// 0 sec, 1 min, 2 hour
	logic        m_alen;
	int          m_sod;	// running time in seconds of day
	int          m_alm;
	logic        m_alarm;
	int          m_idx;
	logic        m_blink_on;

	int unsigned     rng_state;
	int              err_cnt;
	int              fail_tests;
	int              test_cnt;
	clock_pkg::seg_t cap_seg [6];

	clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.BLINK_DIV  (BLINK_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) i_clock_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btns[BTN_MODE]),
		.i_btn_pos   (btns[BTN_POS]),
		.i_btn_inc   (btns[BTN_INC]),
		.i_btn_alarm (btns[BTN_ALARM]),
		.o_seg_enb   (seg_enb),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;	// lcg
		return int'(rng_state >> 16);
	endfunction

	function automatic int rand_below(int n);
		return next_rand() % n;
	endfunction

	function automatic int field_lim(int f);
		return (f == 2) ? 24 : 60;	// modulus of the field
	endfunction

	function automatic int field_of(int sod, int f);
		case (f)
			0:       return sod % 60;
			1:       return (sod / 60) % 60;
			default: return sod / 3600;
		endcase
	endfunction

	// one field up by one, wraps, no carry
	function automatic int step_sod(int sod, int f);
		int unit;
		int v;
		unit = (f == 0) ? 1 : (f == 1) ? 60 : 3600;
		v = field_of(sod, f);
		return sod - v * unit + ((v + 1) % field_lim(f)) * unit;
	endfunction

	function automatic logic strobe_due(int div);
		return (m_cyc > 0) && (m_cyc % div == 0);
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	always @(posedge clk or negedge rst_n) begin
		logic [3:0] press;
		logic       smp;
		if (!rst_n) begin
			m_cyc      <= 0;
			m_s0       <= '0;
			m_s1       <= '0;
			m_s2       <= '0;
			m_inc      <= 1'b0;
			m_mode     <= 0;
			m_pos      <= 0;
			m_alen     <= 1'b0;
			m_sod      <= 0;
			m_alm      <= 0;
			m_alarm    <= 1'b0;
			m_idx      <= 0;
			m_blink_on <= 1'b1;
		end else begin
			smp   = strobe_due(SAMPLE_DIV);
			press = {4{smp}} & m_s0 & m_s1 & ~m_s2;	// new press, two highs after low
			if (smp) begin
				m_s0 <= btns;
				m_s1 <= m_s0;
				m_s2 <= m_s1;
			end
			if (press[BTN_MODE])
				m_mode <= (m_mode + 1) % 3;
			if (press[BTN_POS])
				m_pos <= (m_pos + 1) % 3;
			if (press[BTN_ALARM])
				m_alen <= !m_alen;
			m_inc <= press[BTN_INC];
			if (strobe_due(SEC_DIV) && m_mode != 1)
				m_sod <= (m_sod + 1) % DAY;
			else if (m_inc && m_mode == 1)
				m_sod <= step_sod(m_sod, m_pos);
			if (m_inc && m_mode == 2)
				m_alm <= step_sod(m_alm, m_pos);
			if (!m_alen)
				m_alarm <= 1'b0;
			else if (m_sod == m_alm)
				m_alarm <= 1'b1;
			if (strobe_due(SCAN_DIV))
				m_idx <= (m_idx + 1) % 6;
			if (strobe_due(BLINK_DIV))
				m_blink_on <= !m_blink_on;
			m_cyc <= m_cyc + 1;
		end
	end

	function automatic clock_pkg::seg_t exp_seg(int k);
		int v;
		v = field_of((m_mode == 2) ? m_alm : m_sod, k / 2);
		return SEG_TAB[(k % 2 == 1) ? v / 10 : v % 10];
	endfunction

	function automatic logic exp_dp(int k);
		return (m_mode != 0) && (k == 2 * m_pos);
	endfunction

	function automatic logic [5:0] exp_enb();
		if ((m_mode != 0) && (m_idx / 2 == m_pos) && !m_blink_on)
			return 6'h3f;	// selected field blanked
		return ~(6'h01 << m_idx);
	endfunction

	function automatic int seg_to_digit(clock_pkg::seg_t s);
		int d;
		for (d = 0; d < 10; d++)
			if (SEG_TAB[d] == s)
				return d;
		return 99;	// not a decimal pattern
	endfunction

	function automatic int shown_field(int f);
		return seg_to_digit(cap_seg[2*f+1]) * 10 + seg_to_digit(cap_seg[2*f]);
	endfunction

	function automatic int shown_sod();
		return shown_field(2) * 3600 + shown_field(1) * 60 + shown_field(0);
	endfunction

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_seg(string name, clock_pkg::seg_t got, clock_pkg::seg_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_field(string name, clock_pkg::field_t got, clock_pkg::field_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_enb(string name, logic [5:0] got, logic [5:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// stimulus and display capture
	// ----------------------------------------
	task automatic press(int b);
		@(posedge clk);
		#1 btns[b] = 1'b1;
		repeat (4 * SAMPLE_DIV) @(posedge clk);
		#1 btns[b] = 1'b0;
		repeat (4 * SAMPLE_DIV - 1) @(posedge clk);
	endtask

	task automatic select_mode(int mode);
		while (m_mode != mode)
			press(BTN_MODE);
	endtask

	task automatic select_pos(int pos);
		while (m_pos != pos)
			press(BTN_POS);
	endtask

	// samples on the falling edge until each digit was seen twice with one value
	task automatic read_display();
		int   seen [6];
		int   k;
		int   n;
		logic done;
		for (k = 0; k < 6; k++)
			seen[k] = 0;
		done = 1'b0;
		n = 0;
		while (!done && n < READ_MAX) begin
			@(negedge clk);
			n++;
			check_enb("o_seg_enb", seg_enb, exp_enb());
			check_bit("o_alarm", alarm, m_alarm);
			if ($onehot(~seg_enb)) begin
				for (k = 0; k < 6; k++) begin
					if (!seg_enb[k]) begin
						check_seg($sformatf("o_seg digit %0d", k), seg, exp_seg(k));
						check_bit($sformatf("o_seg_dp digit %0d", k), seg_dp, exp_dp(k));
						if (seen[k] > 0 && cap_seg[k] !== seg)
							seen[k] = 1;	// digit changed, count again
						else
							seen[k]++;
						cap_seg[k] = seg;
					end
				end
			end
			done = 1'b1;
			for (k = 0; k < 6; k++)
				if (seen[k] < 2)
					done = 1'b0;
		end
		if (!done) begin
			$display("Error at %0t: the scan did not show all six digits", $time);
			err_cnt++;
		end
	endtask

	task automatic end_test(string name, int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			fail_tests++;
			$display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - errs_before);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("Timeout at %0t: run did not end within %0d cycles", $time, WATCHDOG_CYC);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int   e0;
		int   f;
		int   k;
		int   n;
		int   start;
		int   sod_before;
		int   target;
		int   alm;
		int   hid;
		int   vis_sel;
		int   vis_oth;
		logic risen;
		rst_n      = 1'b0;
		btns       = '0;
		rng_state  = 8382;
		err_cnt    = 0;
		fail_tests = 0;
		test_cnt   = 0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		e0 = err_cnt;
		read_display();
		for (f = 0; f < 3; f++)
			check_field("shown field", clock_pkg::field_t'(shown_field(f)), 6'd0);
		check_bit("o_alarm", alarm, 1'b0);
		end_test("reset", e0);

		// clock mode, long enough for a minute carry
		e0 = err_cnt;
		n = 60 + rand_below(40);
		repeat (n * SEC_DIV) @(posedge clk);
		read_display();
		check_field("shown sec", clock_pkg::field_t'(shown_field(0)),
			    clock_pkg::field_t'(field_of(m_sod, 0)));
		check_bit("minute carry", shown_field(1) >= 1, 1'b1);
		end_test("clock run", e0);

		e0 = err_cnt;
		select_mode(1);
		f = rand_below(3);
		select_pos(f);
		start = m_sod;
		n = 10 + rand_below(60);
		repeat (n) press(BTN_INC);
		read_display();
		check_field("stepped field", clock_pkg::field_t'(shown_field(f)),
			    clock_pkg::field_t'((field_of(start, f) + n) % field_lim(f)));
		for (k = 0; k < 3; k++)
			if (k != f)
				check_field("frozen field", clock_pkg::field_t'(shown_field(k)),
					    clock_pkg::field_t'(field_of(start, k)));
		end_test("setup", e0);

		e0 = err_cnt;
		sod_before = shown_sod();
		select_mode(2);
		f = rand_below(3);
		select_pos(f);
		start = m_alm;
		n = 10 + rand_below(60);
		repeat (n) press(BTN_INC);
		read_display();
		check_field("alarm field", clock_pkg::field_t'(shown_field(f)),
			    clock_pkg::field_t'((field_of(start, f) + n) % field_lim(f)));
		select_mode(0);
		read_display();
		check_bit("time advanced", shown_sod() != sod_before, 1'b1);
		end_test("alarm set", e0);

		// time set ten seconds before the alarm
		e0 = err_cnt;
		alm = m_alm;
		target = (alm - 10 + DAY) % DAY;
		select_mode(1);
		for (f = 0; f < 3; f++) begin
			select_pos(f);
			n = (field_of(target, f) - field_of(m_sod, f) + field_lim(f)) % field_lim(f);
			repeat (n) press(BTN_INC);
		end
		press(BTN_ALARM);
		select_mode(0);
		@(negedge clk);
		check_bit("o_alarm before match", alarm, 1'b0);
		risen = 1'b0;
		n = 0;
		while (!risen && n < 20 * SEC_DIV) begin
			@(negedge clk);
			n++;
			risen = alarm;
		end
		if (!risen) begin
			$display("Error at %0t: o_alarm did not rise at the alarm time", $time);
			err_cnt++;
		end else begin
			read_display();
			for (f = 0; f < 3; f++)
				check_field("time at alarm", clock_pkg::field_t'(shown_field(f)),
					    clock_pkg::field_t'(field_of(alm, f)));
			repeat (3 * SEC_DIV) @(negedge clk);
			check_bit("o_alarm held", alarm, 1'b1);
		end
		press(BTN_ALARM);
		@(negedge clk);
		check_bit("o_alarm after disable", alarm, 1'b0);
		end_test("alarm match", e0);

		e0 = err_cnt;
		select_mode(1);
		f = rand_below(3);
		select_pos(f);
		hid = 0;
		vis_sel = 0;
		vis_oth = 0;
		repeat (2 * BLINK_DIV) begin
			@(negedge clk);
			check_enb("o_seg_enb", seg_enb, exp_enb());
			if (seg_enb == 6'h3f)
				hid++;
			else if (!seg_enb[2*f] || !seg_enb[2*f+1])
				vis_sel++;
			else if (!m_blink_on)
				vis_oth++;	// other fields during the off phase
		end
		check_bit("selected field blanked", hid > 0, 1'b1);
		check_bit("selected field shown", vis_sel > 0, 1'b1);
		check_bit("other fields shown", vis_oth > 0, 1'b1);
		end_test("blink", e0);

		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: clock_top.sv
`timescale 1ns/100ps
`default_nettype none

module clock_top #(
	parameter int unsigned SEC_DIV    = 50_000_000,	// 50 MHz board clock
	parameter int unsigned SCAN_DIV   = 5_000,
	parameter int unsigned BLINK_DIV  = 12_500_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_btn_mode,
	input  logic            i_btn_pos,
	input  logic            i_btn_inc,
	input  logic            i_btn_alarm,
	output logic [5:0]      o_seg_enb,
	output clock_pkg::seg_t o_seg,
	output logic            o_seg_dp,
	output logic            o_alarm
);

	logic             sec_tick;
	logic             scan_tick;
	logic             blink_tick;
	logic             sample_tick;
	clock_pkg::ctrl_t ctrl;
	logic             inc_pulse;
	clock_pkg::hms_t  shown;

	clock_pkg::field_t [clock_pkg::NUM_FIELDS-1:0] fields;	// [0] is seconds
	clock_pkg::seg_t   [clock_pkg::NUM_DIGITS-1:0] digits;

	tick_gen #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.BLINK_DIV  (BLINK_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_blink_tick  (blink_tick),
		.o_sample_tick (sample_tick)
	);

	button_ctrl u_button_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn_mode    (i_btn_mode),
		.i_btn_pos     (i_btn_pos),
		.i_btn_inc     (i_btn_inc),
		.i_btn_alarm   (i_btn_alarm),
		.o_ctrl        (ctrl),
		.o_inc_pulse   (inc_pulse)
	);

	time_keeper u_time_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_inc_pulse (inc_pulse),
		.i_ctrl      (ctrl),
		.o_shown     (shown),
		.o_alarm     (o_alarm)
	);

	// ----------------------------------------
	// field encoders, ones below tens
	// ----------------------------------------
	assign fields = {shown.hour, shown.min, shown.sec};

	for (genvar g = 0; g < clock_pkg::NUM_FIELDS; g++) begin : g_enc
		field_encoder u_field_encoder (
			.i_value (fields[g]),
			.o_tens  (digits[2*g+1]),
			.o_ones  (digits[2*g])
		);
	end

	display_scan u_display_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_blink_tick (blink_tick),
		.i_ctrl       (ctrl),
		.i_digits     (digits),
		.o_seg_enb    (o_seg_enb),
		.o_seg        (o_seg),
		.o_seg_dp     (o_seg_dp)
	);

endmodule

`default_nettype wire

// File: display_scan.sv
`timescale 1ns/100ps
`default_nettype none

module display_scan (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         i_scan_tick,
	input  logic                                         i_blink_tick,
	input  clock_pkg::ctrl_t                             i_ctrl,
	input  clock_pkg::seg_t [clock_pkg::NUM_DIGITS-1:0]  i_digits,
	output logic [5:0]                                   o_seg_enb,
	output clock_pkg::seg_t                              o_seg,
	output logic                                         o_seg_dp
);

	clock_pkg::digit_idx_t idx;
	logic                  blink_on;	// 1 = selected field visible
	logic                  edit;
	logic                  sel_field;	// idx is in the selected field
	logic                  hide;

	// ----------------------------------------
	// scan index and blink phase
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == clock_pkg::digit_idx_t'(clock_pkg::NUM_DIGITS - 1))
				idx <= '0;
			else
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			blink_on <= 1'b1;
		else if (i_blink_tick)
			blink_on <= ~blink_on;
	end

	// ----------------------------------------
	// outputs follow the index
	// ----------------------------------------
	assign edit      = (i_ctrl.mode == clock_pkg::MODE_SETUP) ||
			   (i_ctrl.mode == clock_pkg::MODE_ALARM);
	assign sel_field = (idx[2:1] == i_ctrl.pos);	// two digits per field
	assign hide      = edit && sel_field && !blink_on;

	assign o_seg_enb = hide ? 6'b11_1111 : ~(6'b00_0001 << idx);	// active low
	assign o_seg     = i_digits[idx];
	assign o_seg_dp  = edit && sel_field && !idx[0];	// ones digit of field

endmodule

`default_nettype wire

// File: field_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module field_encoder (
	input  clock_pkg::field_t i_value,
	output clock_pkg::seg_t   o_tens,
	output clock_pkg::seg_t   o_ones
);

	clock_pkg::digit_t tens;
	clock_pkg::digit_t ones;

	// 0..59 fits in one tens digit
	assign tens = clock_pkg::digit_t'(i_value / 6'd10);
	assign ones = clock_pkg::digit_t'(i_value % 6'd10);

	assign o_tens = clock_pkg::seg_encode(tens);
	assign o_ones = clock_pkg::seg_encode(ones);

endmodule

`default_nettype wire

// File: time_keeper.sv
`timescale 1ns/100ps
`default_nettype none

module time_keeper (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sec_tick,
	input  logic             i_inc_pulse,
	input  clock_pkg::ctrl_t i_ctrl,
	output clock_pkg::hms_t  o_shown,
	output logic             o_alarm
);

	clock_pkg::hms_t time_q;
	clock_pkg::hms_t alarm_q;
	logic            run_en;	// time advances
	logic            set_en;	// setup step on time
	logic            alm_set_en;	// step on alarm
	logic            alarm_q_out;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic clock_pkg::field_t wrap_inc(clock_pkg::field_t v,
						       clock_pkg::field_t lim);
		return (v == lim) ? '0 : v + 1'b1;
	endfunction

	// steps one field, no carry into the next
	function automatic clock_pkg::hms_t step_field(clock_pkg::hms_t t,
						       clock_pkg::pos_e p);
		clock_pkg::hms_t r;
		r = t;
		case (p)
			clock_pkg::POS_SEC:  r.sec  = wrap_inc(t.sec, clock_pkg::SEC_MAX);
			clock_pkg::POS_MIN:  r.min  = wrap_inc(t.min, clock_pkg::SEC_MAX);
			clock_pkg::POS_HOUR: r.hour = wrap_inc(t.hour, clock_pkg::HOUR_MAX);
			default:             r = t;
		endcase
		return r;
	endfunction

	assign run_en     = i_sec_tick && (i_ctrl.mode != clock_pkg::MODE_SETUP);
	assign set_en     = i_inc_pulse && (i_ctrl.mode == clock_pkg::MODE_SETUP);
	assign alm_set_en = i_inc_pulse && (i_ctrl.mode == clock_pkg::MODE_ALARM);

	// ----------------------------------------
	// running time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;
		end else if (run_en) begin
			time_q.sec <= wrap_inc(time_q.sec, clock_pkg::SEC_MAX);
			if (time_q.sec == clock_pkg::SEC_MAX) begin	// carry to min
				time_q.min <= wrap_inc(time_q.min, clock_pkg::SEC_MAX);
				if (time_q.min == clock_pkg::SEC_MAX)
					time_q.hour <= wrap_inc(time_q.hour, clock_pkg::HOUR_MAX);
			end
		end else if (set_en) begin
			time_q <= step_field(time_q, i_ctrl.pos);
		end
	end

	// alarm time, only stepped by hand
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alarm_q <= '0;
		else if (alm_set_en)
			alarm_q <= step_field(alarm_q, i_ctrl.pos);
	end

	// ----------------------------------------
	// alarm level
	// ----------------------------------------
	// set on match, held until alarm_en drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alarm_q_out <= 1'b0;
		else if (time_q == alarm_q)
			alarm_q_out <= i_ctrl.alarm_en;
		else
			alarm_q_out <= alarm_q_out & i_ctrl.alarm_en;
	end

	assign o_alarm = alarm_q_out;
	assign o_shown = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? alarm_q : time_q;

endmodule

`default_nettype wire

// File: button_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module button_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sample_tick,
	input  logic             i_btn_mode,
	input  logic             i_btn_pos,
	input  logic             i_btn_inc,
	input  logic             i_btn_alarm,
	output clock_pkg::ctrl_t o_ctrl,
	output logic             o_inc_pulse
);

	// bit order {alarm, inc, pos, mode}
	logic [3:0] btn;
	logic [3:0] samp;	// latest sample
	logic [3:0] hist1;	// sample before
	logic [3:0] hist2;	// oldest
	logic [3:0] press;

	clock_pkg::ctrl_t ctrl_q;
	logic             inc_q;

	assign btn = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	// ----------------------------------------
	// slow sampling and press detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp  <= '0;
			hist1 <= '0;
			hist2 <= '0;
		end else if (i_sample_tick) begin
			samp  <= btn;
			hist1 <= samp;
			hist2 <= hist1;
		end
	end

	// two high samples after a low one
	assign press = {4{i_sample_tick}} & samp & hist1 & ~hist2;

	// ----------------------------------------
	// mode, position, alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q.mode     <= clock_pkg::MODE_CLOCK;
			ctrl_q.pos      <= clock_pkg::POS_SEC;
			ctrl_q.alarm_en <= 1'b0;
			inc_q           <= 1'b0;
		end else begin
			if (press[0]) begin
				case (ctrl_q.mode)
					clock_pkg::MODE_CLOCK: ctrl_q.mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: ctrl_q.mode <= clock_pkg::MODE_ALARM;
					default:               ctrl_q.mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (press[1]) begin
				case (ctrl_q.pos)
					clock_pkg::POS_SEC: ctrl_q.pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: ctrl_q.pos <= clock_pkg::POS_HOUR;
					default:            ctrl_q.pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (press[3])
				ctrl_q.alarm_en <= ~ctrl_q.alarm_en;
			inc_q <= press[2];	// single cycle strobe
		end
	end

	assign o_ctrl      = ctrl_q;
	assign o_inc_pulse = inc_q;

endmodule

`default_nettype wire

// File: tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tick_gen #(
	parameter int unsigned SEC_DIV    = 50_000_000,
	parameter int unsigned SCAN_DIV   = 5_000,
	parameter int unsigned BLINK_DIV  = 12_500_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_blink_tick,
	output logic o_sample_tick
);

	// order matches the output assignments below
	localparam int unsigned DIV_TAB [4] = '{SEC_DIV, SCAN_DIV, BLINK_DIV, SAMPLE_DIV};

	// ----------------------------------------
	// modulo counters, strobe on wrap
	// ----------------------------------------
	for (genvar g = 0; g < 4; g++) begin : g_div
		localparam int unsigned CW = (DIV_TAB[g] > 1) ? $clog2(DIV_TAB[g]) : 1;

		logic [CW-1:0] cnt;
		logic          tick;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= '0;
				tick <= 1'b0;
			end else if (cnt == CW'(DIV_TAB[g] - 1)) begin
				cnt  <= '0;
				tick <= 1'b1;	// one cycle wide
			end else begin
				cnt  <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

	assign o_sec_tick    = g_div[0].tick;
	assign o_scan_tick   = g_div[1].tick;
	assign o_blink_tick  = g_div[2].tick;
	assign o_sample_tick = g_div[3].tick;

endmodule

`default_nettype wire

// File: clock_pkg.sv
`default_nettype none

package clock_pkg;

	// ----------------------------------------
	// widths with a meaning
	// ----------------------------------------
	typedef logic [6:0] seg_t;		// {a,b,c,d,e,f,g}, 1 lights
	typedef logic [3:0] digit_t;		// one decimal digit
	typedef logic [5:0] field_t;		// 0..59
	typedef logic [2:0] digit_idx_t;	// scan position

	typedef struct packed {
		field_t hour;
		field_t min;
		field_t sec;
	} hms_t;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC  = 2'b00,
		POS_MIN  = 2'b01,
		POS_HOUR = 2'b10
	} pos_e;

	// control state shared between modules
	typedef struct packed {
		mode_e mode;
		pos_e  pos;
		logic  alarm_en;
	} ctrl_t;

	localparam field_t SEC_MAX    = 6'd59;	// also the minute limit
	localparam field_t HOUR_MAX   = 6'd23;
	localparam int     NUM_FIELDS = 3;
	localparam int     NUM_DIGITS = 6;

	// decimal pattern table, blank above 9
	function automatic seg_t seg_encode(digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

endpackage

`default_nettype wire
